/* hdl/tpu_pkg.sv */
package tpu_pkg;

    // ==============================
    // Datapath geometry
    // ==============================
    localparam int LANES  = 3;     // Lanes per row, also tile edge
    localparam int ELEM_W = 8;     // Signed int8 elements
    localparam int ACC_W  = 20;    // Holds 3 x (-128 * -128) with headroom

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    typedef elem_t [LANES-1:0] row_t;       // One buffer or weight row, 24 bits
    typedef acc_t  [LANES-1:0] acc_row_t;   // One accumulator row, 60 bits

    // ==============================
    // Instruction set
    // ==============================
    typedef enum logic [3:0] {
        OP_NOP        = 4'd0,
        OP_LD_WT      = 4'd1,     // Weight rows into the tile
        OP_MATMUL_ACC = 4'd2,     // Add products into accumulators
        OP_MATMUL_CLR = 4'd3,     // Overwrite accumulators
        OP_ST_UB      = 4'd4,     // Saturate accumulators back to buffer
        OP_HALT       = 4'd15
    } opcode_t;

    typedef struct packed {
        opcode_t    opcode;       // [31:28]
        logic [7:0] count;        // Rows to process
        logic [7:0] ub_addr;      // First buffer row
        logic [7:0] aux_addr;     // First weight row or accumulator row
        logic [3:0] spare;
    } instr_t;

    // ==============================
    // Host side
    // ==============================
    typedef enum logic [1:0] {
        TGT_INSTR  = 2'd0,
        TGT_WEIGHT = 2'd1,
        TGT_UB     = 2'd2
    } target_t;

    typedef struct packed {
        logic        wr_en;
        logic        rd_en;       // Reads always come back from the buffer
        target_t     target;
        logic [7:0]  addr;
        logic [31:0] wdata;       // Rows use the low 24 bits
    } host_req_t;

    // Commands traveling beside memory reads
    typedef struct packed {
        logic       valid;
        logic [1:0] row;          // Tile row index
    } wt_load_t;

    typedef struct packed {
        logic       valid;
        logic       clear;        // Overwrite instead of add
        logic [7:0] acc_addr;
    } mac_cmd_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] acc_addr;
        logic [7:0] ub_addr;
    } store_cmd_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] addr;
        row_t       data;         // Saturated row
    } ub_wr_t;

endpackage

/* hdl/tpu_ram.sv */
`timescale 1ns/1ns

module tpu_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 256
) (
    input  logic       clk,
    input  logic       wr_en,
    input  logic [7:0] wr_addr,
    input  word_t      wr_data,
    input  logic       rd_en,
    input  logic [7:0] rd_addr,
    output word_t      rd_data
);

    localparam int AW = $clog2(DEPTH);   // Upper address bits ignored when shallow

    word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[AW-1:0]] <= wr_data;
        end
    end

    // Registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr[AW-1:0]];   // Holds last value otherwise
        end
    end

endmodule

/* hdl/tpu_mxu.sv */
`timescale 1ns/1ns

module tpu_mxu (
    input  logic                 clk,
    input  logic                 reset,
    // Weight load path
    input  tpu_pkg::wt_load_t    wt_load,   // Issued with the weight memory read
    input  tpu_pkg::row_t        wt_row,    // Weight memory data, one cycle later
    // Multiply path
    input  tpu_pkg::mac_cmd_t    mac_in,    // Issued with the buffer read
    input  tpu_pkg::row_t        x_row,     // Buffer data, one cycle later
    output tpu_pkg::mac_cmd_t    mac_out,
    output tpu_pkg::acc_row_t    y_row
);

    localparam int LANES = tpu_pkg::LANES;

    tpu_pkg::wt_load_t wt_q;      // Lined up with wt_row
    tpu_pkg::mac_cmd_t mac_q;     // Lined up with x_row
    tpu_pkg::row_t     tile [LANES];
    tpu_pkg::acc_row_t dot;

    // ==============================
    // Command alignment
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            wt_q  <= '0;
            mac_q <= '0;
        end else begin
            wt_q  <= wt_load;
            mac_q <= mac_in;
        end
    end

    // Tile rows, written one per load step
    always_ff @(posedge clk) begin
        if (wt_q.valid) begin
            tile[wt_q.row] <= wt_row;
        end
    end

    // ==============================
    // Row times tile
    // ==============================
    // y[j] = sum over i of x[i] * W[i][j]
    always_comb begin
        dot = '0;
        for (int j = 0; j < LANES; j++) begin
            for (int i = 0; i < LANES; i++) begin
                dot[j] = dot[j] + x_row[i] * tile[i][j];   // Signed, sized to ACC_W
            end
        end
    end

    // Result stage, second cycle after issue
    always_ff @(posedge clk) begin
        if (reset) begin
            mac_out <= '0;
        end else begin
            mac_out <= mac_q;
        end
    end

    always_ff @(posedge clk) begin
        if (mac_q.valid) begin
            y_row <= dot;   // Only valid rows move the payload
        end
    end

endmodule

/* hdl/tpu_acc_buffer.sv */
`timescale 1ns/1ns

module tpu_acc_buffer #(
    parameter int ACC_ROWS = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  tpu_pkg::mac_cmd_t     mac_in,   // From MXU, already aligned with y_row
    input  tpu_pkg::acc_row_t     y_row,
    input  tpu_pkg::store_cmd_t   store,
    output tpu_pkg::ub_wr_t       ub_wr
);

    localparam int AW = $clog2(ACC_ROWS);

    localparam tpu_pkg::acc_t SAT_MAX = 127;
    localparam tpu_pkg::acc_t SAT_MIN = -128;

    tpu_pkg::acc_row_t acc [ACC_ROWS];

    // Clamp one lane into int8
    function automatic tpu_pkg::elem_t sat8(input tpu_pkg::acc_t v);
        if (v > SAT_MAX) begin
            return tpu_pkg::elem_t'(SAT_MAX);
        end else if (v < SAT_MIN) begin
            return tpu_pkg::elem_t'(SAT_MIN);
        end
        return v[tpu_pkg::ELEM_W-1:0];
    endfunction

    // ==============================
    // Accumulate
    // ==============================
    always_ff @(posedge clk) begin
        if (mac_in.valid) begin
            if (mac_in.clear) begin
                acc[mac_in.acc_addr[AW-1:0]] <= y_row;   // MATMUL_CLR
            end else begin
                for (int j = 0; j < tpu_pkg::LANES; j++) begin
                    acc[mac_in.acc_addr[AW-1:0]][j] <= acc[mac_in.acc_addr[AW-1:0]][j] + y_row[j];
                end
            end
        end
    end

    // ==============================
    // Store read-out
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            ub_wr.valid <= 1'b0;
        end else begin
            ub_wr.valid <= store.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (store.valid) begin
            ub_wr.addr <= store.ub_addr;
            for (int j = 0; j < tpu_pkg::LANES; j++) begin
                ub_wr.data[j] <= sat8(acc[store.acc_addr[AW-1:0]][j]);   // Lane by lane
            end
        end
    end

endmodule

/* hdl/tpu_controller.sv */
`timescale 1ns/1ns

module tpu_controller #(
    parameter int IMEM_DEPTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,       // One-cycle pulse from host
    // Instruction fetch
    output logic                  imem_rd_en,
    output logic [7:0]            imem_addr,
    input  tpu_pkg::instr_t       instr,       // Valid in decode
    // Weight load
    output logic                  wmem_rd_en,
    output logic [7:0]            wmem_addr,
    output tpu_pkg::wt_load_t     wt_load,
    // Multiply
    output logic                  ub_rd_en,
    output logic [7:0]            ub_rd_addr,
    output tpu_pkg::mac_cmd_t     mac_cmd,
    // Store
    output tpu_pkg::store_cmd_t   store,
    // Status
    output logic                  busy,
    output logic                  done
);

    localparam int PCW          = $clog2(IMEM_DEPTH);
    localparam int DRAIN_CYCLES = 3;    // Covers RAM, multiply and accumulate stages

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_ISSUE,
        S_DRAIN,
        S_HALT
    } state_t;

    state_t           state;
    logic [PCW-1:0]   pc;
    tpu_pkg::instr_t  ir;           // Instruction being issued
    logic [7:0]       row_cnt;
    logic [7:0]       row_total;
    logic [1:0]       drain_cnt;
    logic             issue;

    // ==============================
    // Sequencer
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            pc        <= '0;
            row_cnt   <= '0;
            row_total <= '0;
            drain_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;   // Pulse only
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_DECODE;   // Read issued this cycle
                S_DECODE: begin
                    pc        <= pc + 1'b1;
                    row_cnt   <= '0;
                    drain_cnt <= '0;
                    // Weight load always covers the whole tile
                    if (instr.opcode == tpu_pkg::OP_LD_WT) begin
                        row_total <= 8'(tpu_pkg::LANES);
                    end else begin
                        row_total <= instr.count;
                    end
                    case (instr.opcode)
                        tpu_pkg::OP_HALT:  state <= S_HALT;
                        tpu_pkg::OP_LD_WT: state <= S_ISSUE;
                        tpu_pkg::OP_MATMUL_ACC,
                        tpu_pkg::OP_MATMUL_CLR,
                        tpu_pkg::OP_ST_UB: begin
                            state <= (instr.count == 8'd0) ? S_DRAIN : S_ISSUE;
                        end
                        tpu_pkg::OP_NOP:   state <= S_FETCH;
                        default:           state <= S_FETCH;   // Unknown opcodes skipped
                    endcase
                end
                S_ISSUE: begin
                    row_cnt <= row_cnt + 8'd1;
                    if (row_cnt == row_total - 8'd1) begin
                        state <= S_DRAIN;   // Last row out
                    end
                end
                S_DRAIN: begin
                    drain_cnt <= drain_cnt + 2'd1;
                    if (drain_cnt == 2'(DRAIN_CYCLES - 1)) begin
                        state <= S_FETCH;
                    end
                end
                S_HALT: begin
                    done  <= 1'b1;   // Same edge busy drops
                    pc    <= '0;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Instruction register, loaded in decode
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            ir <= instr;
        end
    end

    // ==============================
    // Fetch and issue outputs
    // ==============================
    assign busy       = (state != S_IDLE);
    assign imem_rd_en = (state == S_FETCH);
    assign imem_addr  = 8'(pc);
    assign issue      = (state == S_ISSUE);

    always_comb begin
        wmem_addr        = ir.aux_addr + row_cnt;
        ub_rd_addr       = ir.ub_addr + row_cnt;
        wmem_rd_en       = 1'b0;
        ub_rd_en         = 1'b0;
        wt_load.valid    = 1'b0;
        wt_load.row      = row_cnt[1:0];
        mac_cmd.valid    = 1'b0;
        mac_cmd.clear    = (ir.opcode == tpu_pkg::OP_MATMUL_CLR);
        mac_cmd.acc_addr = ir.aux_addr + row_cnt;
        store.valid      = 1'b0;
        store.acc_addr   = ir.aux_addr + row_cnt;
        store.ub_addr    = ir.ub_addr + row_cnt;
        if (issue) begin
            case (ir.opcode)
                tpu_pkg::OP_LD_WT: begin
                    wmem_rd_en    = 1'b1;
                    wt_load.valid = 1'b1;
                end
                tpu_pkg::OP_MATMUL_ACC,
                tpu_pkg::OP_MATMUL_CLR: begin
                    ub_rd_en      = 1'b1;   // Input row from buffer
                    mac_cmd.valid = 1'b1;
                end
                tpu_pkg::OP_ST_UB: store.valid = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/tpu_top.sv */
`timescale 1ns/1ns

module tpu_top #(
    parameter int IMEM_DEPTH = 32,
    parameter int WMEM_DEPTH = 256,
    parameter int UB_DEPTH   = 256,
    parameter int ACC_ROWS   = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  tpu_pkg::host_req_t  host,
    input  logic                start,
    output logic                busy,
    output logic                done,
    output tpu_pkg::row_t       rd_data,    // Buffer read data
    output logic                rd_valid    // Flags host reads only
);

    localparam int ROW_W = $bits(tpu_pkg::row_t);

    logic                 imem_rd_en;
    logic [7:0]           imem_addr;
    tpu_pkg::instr_t      instr;
    logic                 wmem_rd_en;
    logic [7:0]           wmem_addr;
    tpu_pkg::row_t        wt_row;
    tpu_pkg::wt_load_t    wt_load;
    logic                 ctrl_ub_rd_en;
    logic [7:0]           ctrl_ub_rd_addr;
    tpu_pkg::mac_cmd_t    mac_cmd;
    tpu_pkg::mac_cmd_t    mac_res;
    tpu_pkg::acc_row_t    y_row;
    tpu_pkg::store_cmd_t  store;
    tpu_pkg::ub_wr_t      acc_wr;
    tpu_pkg::row_t        ub_rd_data;

    // Muxed buffer port
    logic                 host_act;
    logic                 host_ub_rd;
    logic                 ub_wr_en;
    logic [7:0]           ub_wr_addr;
    tpu_pkg::row_t        ub_wr_data;
    logic                 ub_rd_en;
    logic [7:0]           ub_rd_addr;

    tpu_controller #(.IMEM_DEPTH(IMEM_DEPTH)) u_ctrl (
        .clk, .reset, .start,
        .imem_rd_en, .imem_addr, .instr,
        .wmem_rd_en, .wmem_addr, .wt_load,
        .ub_rd_en(ctrl_ub_rd_en), .ub_rd_addr(ctrl_ub_rd_addr), .mac_cmd,
        .store, .busy, .done
    );

    // ==============================
    // Memories
    // ==============================
    tpu_ram #(.word_t(tpu_pkg::instr_t), .DEPTH(IMEM_DEPTH)) u_imem (
        .clk,
        .wr_en(host.wr_en && host.target == tpu_pkg::TGT_INSTR),
        .wr_addr(host.addr), .wr_data(tpu_pkg::instr_t'(host.wdata)),
        .rd_en(imem_rd_en), .rd_addr(imem_addr), .rd_data(instr)
    );

    tpu_ram #(.word_t(tpu_pkg::row_t), .DEPTH(WMEM_DEPTH)) u_wmem (
        .clk,
        .wr_en(host.wr_en && host.target == tpu_pkg::TGT_WEIGHT),
        .wr_addr(host.addr), .wr_data(tpu_pkg::row_t'(host.wdata[ROW_W-1:0])),
        .rd_en(wmem_rd_en), .rd_addr(wmem_addr), .rd_data(wt_row)
    );

    // Host wins the buffer port whenever it strobes
    assign host_act   = host.wr_en | host.rd_en;
    assign host_ub_rd = host.rd_en && host.target == tpu_pkg::TGT_UB;
    assign ub_wr_en   = host_act ? (host.wr_en && host.target == tpu_pkg::TGT_UB) : acc_wr.valid;
    assign ub_wr_addr = host_act ? host.addr : acc_wr.addr;
    assign ub_wr_data = host_act ? tpu_pkg::row_t'(host.wdata[ROW_W-1:0]) : acc_wr.data;
    assign ub_rd_en   = host_act ? host_ub_rd : ctrl_ub_rd_en;
    assign ub_rd_addr = host_act ? host.addr : ctrl_ub_rd_addr;

    tpu_ram #(.word_t(tpu_pkg::row_t), .DEPTH(UB_DEPTH)) u_ub (
        .clk, .wr_en(ub_wr_en), .wr_addr(ub_wr_addr), .wr_data(ub_wr_data),
        .rd_en(ub_rd_en), .rd_addr(ub_rd_addr), .rd_data(ub_rd_data)
    );

    // ==============================
    // Compute
    // ==============================
    tpu_mxu u_mxu (
        .clk, .reset, .wt_load, .wt_row,
        .mac_in(mac_cmd), .x_row(ub_rd_data), .mac_out(mac_res), .y_row
    );

    tpu_acc_buffer #(.ACC_ROWS(ACC_ROWS)) u_acc (
        .clk, .reset, .mac_in(mac_res), .y_row, .store, .ub_wr(acc_wr)
    );

    // Host read return, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= host_ub_rd;
        end
    end

    assign rd_data = ub_rd_data;

endmodule

/* tb/tpu_chk.sv */
`timescale 1ns/1ns

module tpu_chk (
    input  logic                clk,
    input  logic                reset,
    input  tpu_pkg::host_req_t  host,
    input  logic                busy,
    input  logic                done
);

    int fail_count = 0;   // Count of failed assertions

    // Host owns memories only while the controller is idle
    a_no_write_busy: assert property (@(posedge clk) disable iff (reset)
        !(host.wr_en && busy))
        else begin
            $error("host write strobe while busy");
            fail_count++;
        end

    // Done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin
            $error("done high on two consecutive cycles");
            fail_count++;
        end

    a_idle_after_done: assert property (@(posedge clk) disable iff (reset)
        done |=> !busy)
        else begin
            $error("busy high in the cycle after done");
            fail_count++;
        end

endmodule

/* tb/tb_tpu.sv */
`timescale 1ns/1ns

module tb_tpu;

    localparam int IMEM_DEPTH = 32;
    localparam int WMEM_DEPTH = 256;
    localparam int UB_DEPTH   = 256;
    localparam int ACC_ROWS   = 16;
    // Longest random run near 100 cycles with host traffic, 20 of them plus directed tests
    localparam int CYCLE_LIMIT = 20000;

    logic                clk;
    logic                reset;
    tpu_pkg::host_req_t  host;
    logic                start;
    logic                busy;
    logic                done;
    tpu_pkg::row_t       rd_data;
    logic                rd_valid;

    // Model of memories and accumulators
    tpu_pkg::row_t       ub_m   [UB_DEPTH];
    tpu_pkg::row_t       wt_m   [WMEM_DEPTH];
    tpu_pkg::row_t       tile_m [tpu_pkg::LANES];
    int                  acc_m  [ACC_ROWS][tpu_pkg::LANES];
    tpu_pkg::instr_t     prog_m [IMEM_DEPTH];
    int                  prog_len;

    tpu_pkg::row_t       exp_q [$];     // Expected host read data, in issue order
    tpu_pkg::row_t       cmp_exp;
    int                  errors;
    int                  checks;
    int                  cycles;

    tpu_top #(
        .IMEM_DEPTH(IMEM_DEPTH), .WMEM_DEPTH(WMEM_DEPTH),
        .UB_DEPTH(UB_DEPTH), .ACC_ROWS(ACC_ROWS)
    ) DUT (
        .clk, .reset, .host, .start, .busy, .done, .rd_data, .rd_valid
    );

    bind tpu_top tpu_chk u_chk (.clk, .reset, .host, .busy, .done);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ==============================
    // Reference model
    // ==============================
    function automatic tpu_pkg::elem_t clamp_int8(int v);
        if (v > 127) begin
            return 8'h7f;
        end else if (v < -128) begin
            return 8'h80;
        end
        return 8'(v);
    endfunction

    // Walks the stored program in order, each instruction fully retired
    function automatic void model_run();
        tpu_pkg::instr_t ins;
        tpu_pkg::row_t   x;
        int              pc;
        int              a;
        int              sum;
        bit              running;
        pc = 0;
        running = 1'b1;
        while (running && pc < IMEM_DEPTH) begin
            ins = prog_m[pc];
            pc++;
            case (ins.opcode)
                tpu_pkg::OP_LD_WT: begin
                    for (int k = 0; k < tpu_pkg::LANES; k++) begin
                        tile_m[k] = wt_m[8'(int'(ins.aux_addr) + k)];
                    end
                end
                tpu_pkg::OP_MATMUL_ACC,
                tpu_pkg::OP_MATMUL_CLR: begin
                    for (int k = 0; k < int'(ins.count); k++) begin
                        x = ub_m[8'(int'(ins.ub_addr) + k)];
                        a = (int'(ins.aux_addr) + k) & (ACC_ROWS - 1);
                        for (int j = 0; j < tpu_pkg::LANES; j++) begin
                            sum = 0;
                            for (int i = 0; i < tpu_pkg::LANES; i++) begin
                                sum += int'(x[i]) * int'(tile_m[i][j]);   // Row times column j
                            end
                            if (ins.opcode == tpu_pkg::OP_MATMUL_CLR) begin
                                acc_m[a][j] = sum;
                            end else begin
                                acc_m[a][j] += sum;
                            end
                        end
                    end
                end
                tpu_pkg::OP_ST_UB: begin
                    for (int k = 0; k < int'(ins.count); k++) begin
                        a = (int'(ins.aux_addr) + k) & (ACC_ROWS - 1);
                        for (int j = 0; j < tpu_pkg::LANES; j++) begin
                            ub_m[8'(int'(ins.ub_addr) + k)][j] = clamp_int8(acc_m[a][j]);
                        end
                    end
                end
                tpu_pkg::OP_HALT: running = 1'b0;
                default: ;   // NOP and unknown codes
            endcase
        end
    endfunction

    // ==============================
    // Compare process
    // ==============================
    always @(negedge clk) begin
        if (!reset && rd_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Error at %0t: read data returned with no host read outstanding", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                cmp_exp = exp_q.pop_front();
                checks++;
                assert (rd_data == cmp_exp) else begin
                    $display("Error at %0t: rd_data = %h, expected %h", $time, rd_data, cmp_exp);
                    errors++;
                end
            end
        end
    end

    // ==============================
    // Host side tasks
    // ==============================
    task automatic step();
        @(posedge clk);
        #1;   // Drive point
    endtask

    function automatic tpu_pkg::row_t make_row(int a, int b, int c);
        tpu_pkg::row_t r;
        r[0] = 8'(a);
        r[1] = 8'(b);
        r[2] = 8'(c);
        return r;
    endfunction

    function automatic tpu_pkg::row_t rand_row(int mag);
        tpu_pkg::row_t r;
        for (int j = 0; j < tpu_pkg::LANES; j++) begin
            r[j] = 8'(int'($urandom_range(0, 2 * mag)) - mag);   // Uniform in -mag..mag
        end
        return r;
    endfunction

    task automatic host_write(tpu_pkg::target_t tgt, int addr, logic [31:0] data);
        host.wr_en = 1'b1;
        host.target = tgt;
        host.addr = 8'(addr);
        host.wdata = data;
        step();
        host.wr_en = 1'b0;
    endtask

    task automatic ub_write(int addr, tpu_pkg::row_t row);
        ub_m[addr] = row;
        host_write(tpu_pkg::TGT_UB, addr, 32'(row));
    endtask

    task automatic weight_write(int addr, tpu_pkg::row_t row);
        wt_m[addr] = row;
        host_write(tpu_pkg::TGT_WEIGHT, addr, 32'(row));
    endtask

    // Host read, expected row supplied by caller
    task automatic read_expect(int addr, tpu_pkg::row_t exp);
        host.rd_en = 1'b1;
        host.target = tpu_pkg::TGT_UB;
        host.addr = 8'(addr);
        exp_q.push_back(exp);
        step();
        host.rd_en = 1'b0;
    endtask

    task automatic read_model(int addr);
        read_expect(addr, ub_m[addr]);
    endtask

    task automatic add_instr(tpu_pkg::opcode_t op, int count, int ub, int aux);
        tpu_pkg::instr_t ins;
        ins = '0;
        ins.opcode = op;
        ins.count = 8'(count);
        ins.ub_addr = 8'(ub);
        ins.aux_addr = 8'(aux);
        prog_m[prog_len] = ins;
        host_write(tpu_pkg::TGT_INSTR, prog_len, 32'(ins));
        prog_len++;
    endtask

    // Start pulse, then busy high until one done pulse with busy low
    task automatic run_program();
        bit done_seen;
        model_run();
        start = 1'b1;
        step();
        start = 1'b0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            checks++;
            if (done) begin
                done_seen = 1'b1;
                assert (!busy) else begin
                    $display("Error at %0t: busy = %b, expected 0", $time, busy);
                    errors++;
                end
            end else begin
                assert (busy) else begin
                    $display("Error at %0t: busy = %b, expected 1", $time, busy);
                    errors++;
                end
            end
        end
        repeat (3) begin
            @(negedge clk);
            checks++;
            assert (!done) else begin
                $display("Error at %0t: done = %b, expected 0", $time, done);
                errors++;
            end
            assert (!busy) else begin
                $display("Error at %0t: busy = %b, expected 0", $time, busy);
                errors++;
            end
        end
        step();
    endtask

    task automatic end_test(int num, string name, int err_start);
        repeat (2) step();   // Last read lands
        if (errors == err_start) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", num, name, errors - err_start);
        end
    endtask

    // ==============================
    // Tests
    // ==============================
    initial begin
        int err_start;
        int wbase;
        int xbase;
        int abase;
        int obase;
        int n;
        int mag;
        bit use_acc;
        void'($urandom(60907));
        reset = 1'b1;
        host = '0;
        start = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        prog_len = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Test 1 status after reset, buffer write and read back
        err_start = errors;
        checks++;
        assert (!busy && !done && !rd_valid) else begin
            $display("Error at %0t: busy/done/rd_valid = %b%b%b, expected 000",
                     $time, busy, done, rd_valid);
            errors++;
        end
        for (int k = 0; k < 8; k++) begin
            ub_write(8'hf0 + k, rand_row(127));
        end
        for (int k = 0; k < 8; k++) begin
            read_model(8'hf0 + k);
        end
        end_test(1, "reset_and_host_access", err_start);

        // Test 2 load, multiply with clear, store
        err_start = errors;
        for (int k = 0; k < 3; k++) begin
            weight_write(k, rand_row(20));
        end
        for (int k = 0; k < 4; k++) begin
            ub_write(k, rand_row(20));
        end
        prog_len = 0;
        add_instr(tpu_pkg::OP_LD_WT, 0, 0, 0);
        add_instr(tpu_pkg::OP_MATMUL_CLR, 4, 0, 0);
        add_instr(tpu_pkg::OP_ST_UB, 4, 8'h40, 0);
        add_instr(tpu_pkg::OP_HALT, 0, 0, 0);
        run_program();
        for (int k = 0; k < 4; k++) begin
            read_model(8'h40 + k);
        end
        end_test(2, "matmul_clr_store", err_start);

        // Test 3 accumulate twice, then saturation
        err_start = errors;
        weight_write(8'h10, make_row(1, 2, 0));
        weight_write(8'h11, make_row(0, 1, -1));
        weight_write(8'h12, make_row(3, 0, 1));
        for (int k = 0; k < 3; k++) begin
            weight_write(8'h18 + k, make_row(127, 127, 127));
        end
        ub_write(8'h20, make_row(5, -3, 2));       // Products 11 7 5
        ub_write(8'h21, make_row(-7, 4, 1));       // Products -4 -10 -3
        ub_write(8'h22, make_row(127, 127, 127));
        ub_write(8'h23, make_row(-128, -128, -128));
        prog_len = 0;
        add_instr(tpu_pkg::OP_LD_WT, 0, 0, 8'h10);
        add_instr(tpu_pkg::OP_MATMUL_CLR, 2, 8'h20, 4);
        add_instr(tpu_pkg::OP_MATMUL_ACC, 2, 8'h20, 4);
        add_instr(tpu_pkg::OP_ST_UB, 2, 8'h50, 4);
        add_instr(tpu_pkg::OP_LD_WT, 0, 0, 8'h18);
        add_instr(tpu_pkg::OP_MATMUL_CLR, 2, 8'h22, 8);
        add_instr(tpu_pkg::OP_ST_UB, 2, 8'h52, 8);
        add_instr(tpu_pkg::OP_HALT, 0, 0, 0);
        run_program();
        read_expect(8'h50, make_row(22, 14, 10));
        read_expect(8'h51, make_row(-8, -20, -6));
        read_expect(8'h52, make_row(127, 127, 127));       // 48387 clamps high
        read_expect(8'h53, make_row(-128, -128, -128));    // -48768 clamps low
        end_test(3, "accumulate_and_saturate", err_start);

        // Test 4 busy and done around a short program
        err_start = errors;
        prog_len = 0;
        add_instr(tpu_pkg::OP_NOP, 0, 0, 0);
        add_instr(tpu_pkg::OP_MATMUL_CLR, 0, 0, 0);   // Zero rows, drain only
        add_instr(tpu_pkg::OP_HALT, 0, 0, 0);
        run_program();
        end_test(4, "busy_done_status", err_start);

        // Test 5 random tiles, rows and counts
        err_start = errors;
        for (int it = 0; it < 20; it++) begin
            wbase = int'($urandom_range(0, 253));
            n = int'($urandom_range(1, 8));
            xbase = int'($urandom_range(0, 8'h70));
            abase = int'($urandom_range(0, ACC_ROWS - n));
            obase = int'($urandom_range(8'h80, 8'hf8 - n));
            mag = ($urandom_range(0, 1) == 0) ? 10 : 127;
            use_acc = 1'($urandom_range(0, 1));
            for (int k = 0; k < 3; k++) begin
                weight_write(wbase + k, rand_row(mag));
            end
            for (int k = 0; k < 2 * n; k++) begin
                ub_write(xbase + k, rand_row(mag));
            end
            prog_len = 0;
            add_instr(tpu_pkg::OP_LD_WT, 0, 0, wbase);
            add_instr(tpu_pkg::OP_MATMUL_CLR, n, xbase, abase);
            if (use_acc) begin
                add_instr(tpu_pkg::OP_MATMUL_ACC, n, xbase + n, abase);
            end
            add_instr(tpu_pkg::OP_ST_UB, n, obase, abase);
            add_instr(tpu_pkg::OP_HALT, 0, 0, 0);
            run_program();
            for (int k = 0; k < n; k++) begin
                read_model(obase + k);
            end
        end
        end_test(5, "random_programs", err_start);

        checks++;
        assert (exp_q.size() == 0) else begin
            $display("Error: %0d host reads returned no data", exp_q.size());
            errors++;
        end
        errors += DUT.u_chk.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* all.f */
hdl/tpu_pkg.sv
hdl/tpu_ram.sv
hdl/tpu_mxu.sv
hdl/tpu_acc_buffer.sv
hdl/tpu_controller.sv
hdl/tpu_top.sv
tb/tpu_chk.sv
tb/tb_tpu.sv

/* Makefile */
# Verilator build and run for the TPU matrix unit testbench

VERILATOR  ?= verilator
TOP        ?= tb_tpu
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
RUN_ARGS   ?= +verilator+error+limit+100
PASS_MSG   ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass line appears in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
